// ==== Makefile ====
# Verilator build and run of the machine CSR block testbench

VERILATOR ?= verilator
TOP       ?= csr_tb
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
FILELIST  ?= verilog.f
PASS_MSG  ?= Simulation completed successfully

SRCS := $(shell grep -v '^+' $(FILELIST)) $(wildcard source/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== source/csr_arbiter.sv ====
//////////////////////////////////////////////////////////////////////
// round-robin arbiter between the core and host CSR masters
// grants are combinational and only while the register file is ready
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_arbiter (
  input  logic                 clk,
  input  logic                 rst,
  // core master
  input  logic                 core_req_i,
  input  csr_isa_pkg::csr_op_t core_op_i,
  input  logic [`CSR_AW-1:0]   core_adr_i,
  input  logic [`CSR_XLEN-1:0] core_opd_i,
  output logic                 core_gnt_o,
  output logic [`CSR_XLEN-1:0] core_rdata_o,
  // host master
  input  logic                 host_req_i,
  input  csr_isa_pkg::csr_op_t host_op_i,
  input  logic [`CSR_AW-1:0]   host_adr_i,
  input  logic [`CSR_XLEN-1:0] host_opd_i,
  output logic                 host_gnt_o,
  output logic [`CSR_XLEN-1:0] host_rdata_o,
  // register file side
  input  logic                 bus_ready_i,  // low in trap/mret cycles
  output logic                 bus_we_o,     // granted access
  output csr_isa_pkg::csr_op_t bus_op_o,
  output logic [`CSR_AW-1:0]   bus_adr_o,
  output logic [`CSR_XLEN-1:0] bus_opd_o,
  input  logic [`CSR_XLEN-1:0] bus_rdata_i
);

  import csr_isa_pkg::*;
  import csr_bus_pkg::*;

  arb_state_t  prio;      // tie winner
  bus_master_t sel;       // who owns the bus this cycle
  logic        core_win;  // core beats host
  logic        tie;

  //////////////////////////////////////////////////////////////////////
  // grant
  //////////////////////////////////////////////////////////////////////

  assign tie      = core_req_i && host_req_i;
  assign core_win = core_req_i && (!host_req_i || prio == PRIO_CORE);
  assign sel      = core_win ? MST_CORE : MST_HOST;

  assign core_gnt_o = bus_ready_i && core_win;
  assign host_gnt_o = bus_ready_i && host_req_i && !core_win;
  assign bus_we_o   = core_gnt_o || host_gnt_o;

  // flip only when a tie was actually served
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      prio <= PRIO_CORE;
    end else if (tie && bus_ready_i) begin
      prio <= (prio == PRIO_CORE) ? PRIO_HOST : PRIO_CORE;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus mux and read data fan-out
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    case (sel)
      MST_CORE: begin
        bus_op_o  = core_op_i;
        bus_adr_o = core_adr_i;
        bus_opd_o = core_opd_i;
      end
      default: begin
        bus_op_o  = host_op_i;
        bus_adr_o = host_adr_i;
        bus_opd_o = host_opd_i;
      end
    endcase
  end

  // masters sample only on their own grant
  assign core_rdata_o = bus_rdata_i;
  assign host_rdata_o = bus_rdata_i;

  // a waiting master keeps its request and address up
  a_core_hold: assert property (@(posedge clk) disable iff (rst)
    core_req_i && !core_gnt_o |=> core_req_i && $stable(core_adr_i))
    else $error("arbiter: core request dropped before its grant");

  a_host_hold: assert property (@(posedge clk) disable iff (rst)
    host_req_i && !host_gnt_o |=> host_req_i && $stable(host_adr_i))
    else $error("arbiter: host request dropped before its grant");

endmodule

// ==== source/csr_bus_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// CSR bus types shared by the arbiter and its masters
//////////////////////////////////////////////////////////////////////

package csr_bus_pkg;

  // bus masters, used as the mux select
  typedef enum logic {
    MST_CORE = 1'b0,  // Zicsr unit
    MST_HOST = 1'b1   // debug/host port
  } bus_master_t;

  // round-robin state, who wins the next tie
  typedef enum logic {
    PRIO_CORE = 1'b0,
    PRIO_HOST = 1'b1
  } arb_state_t;

endpackage

// ==== source/csr_consts.svh ====
//////////////////////////////////////////////////////////////////////
// widths and reset values of the machine CSR block
// include wherever a port width or a constant register value is needed
//////////////////////////////////////////////////////////////////////

`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// datapath width, RV32 only
`define CSR_XLEN 32

// CSR address field of the Zicsr instructions
`define CSR_AW 12

// misa: MXL=1 in bits 31:30, extension bit I (8) set
`define CSR_MISA_VAL 32'h4000_0100

// mtvec after reset, direct mode so bits 1:0 stay zero
`define CSR_MTVEC_RST 32'h0000_0100

`endif

// ==== source/csr_host_port.sv ====
//////////////////////////////////////////////////////////////////////
// host/debug side CSR bus master, one read or write at a time
// pulse host_rd_i or host_wr_i, result comes with host_ack_o
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_host_port (
  input  logic                 clk,
  input  logic                 rst,
  // host access
  input  logic                 host_rd_i,     // read pulse
  input  logic                 host_wr_i,     // write pulse
  input  logic [`CSR_AW-1:0]   host_adr_i,
  input  logic [`CSR_XLEN-1:0] host_wdata_i,
  // CSR bus request side
  output logic                 req_o,
  output csr_isa_pkg::csr_op_t op_o,
  output logic [`CSR_AW-1:0]   adr_o,
  output logic [`CSR_XLEN-1:0] opd_o,
  input  logic                 gnt_i,
  input  logic [`CSR_XLEN-1:0] rdata_i,
  // completion
  output logic                 host_ack_o,
  output logic [`CSR_XLEN-1:0] host_rdata_o
);

  import csr_isa_pkg::*;

  logic accept;  // access taken this edge

  assign accept = (host_rd_i || host_wr_i) && !req_o;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_o      <= 1'b0;
      host_ack_o <= 1'b0;
    end else begin
      host_ack_o <= req_o && gnt_i;
      if (accept) begin
        req_o <= 1'b1;
      end else if (gnt_i) begin
        req_o <= 1'b0;
      end
    end
  end

  // payload, a write is a plain RW, a read never writes
  always_ff @(posedge clk) begin
    if (accept) begin
      op_o  <= host_wr_i ? CSR_RW : CSR_NOP;
      adr_o <= host_adr_i;
      opd_o <= host_wdata_i;
    end
    if (req_o && gnt_i) begin
      host_rdata_o <= rdata_i;
    end
  end

  a_rd_wr_excl: assert property (@(posedge clk) disable iff (rst)
    !(host_rd_i && host_wr_i))
    else $error("host: read and write in the same cycle");

  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    (host_rd_i || host_wr_i) |-> !req_o)
    else $error("host: access dropped, port still busy");

endmodule

// ==== source/csr_isa_pkg.sv ====
//////////////////////////////////////////////////////////////////////
// ISA level types of the Zicsr extension
// opcodes, operand sources and the implemented machine CSR addresses
//////////////////////////////////////////////////////////////////////

`include "csr_consts.svh"

package csr_isa_pkg;

  // funct3[1:0] of the Zicsr instructions, 00 left over for a plain read
  typedef enum logic [1:0] {
    CSR_NOP = 2'b00,  // read only, no write
    CSR_RW  = 2'b01,  // csrrw / csrrwi
    CSR_SET = 2'b10,  // csrrs / csrrsi
    CSR_CLR = 2'b11   // csrrc / csrrci
  } csr_op_t;

  // funct3[2], where the operand comes from
  typedef enum logic {
    CSR_REG = 1'b0,  // rs1 value
    CSR_IMM = 1'b1   // 5-bit zimm, zero extended
  } csr_src_t;

  // machine level registers that exist here
  typedef enum logic [`CSR_AW-1:0] {
    MSTATUS  = 12'h300,
    MISA     = 12'h301,
    MTVEC    = 12'h305,
    MSCRATCH = 12'h340,
    MEPC     = 12'h341,
    MCAUSE   = 12'h342
  } csr_addr_t;

endpackage

// ==== source/csr_regfile.sv ====
//////////////////////////////////////////////////////////////////////
// machine mode CSRs: bus read-modify-write, trap entry and mret
// read is combinational, writes land on the edge of a granted cycle
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_regfile (
  input  logic                 clk,
  input  logic                 rst,
  // CSR bus
  input  logic                 bus_we_i,     // granted access
  input  csr_isa_pkg::csr_op_t bus_op_i,
  input  logic [`CSR_AW-1:0]   bus_adr_i,
  input  logic [`CSR_XLEN-1:0] bus_opd_i,
  output logic [`CSR_XLEN-1:0] bus_rdata_o,  // old value
  output logic                 bus_ready_o,
  // trap control
  input  logic                 trap_i,
  input  logic [`CSR_XLEN-1:0] cause_i,
  input  logic [`CSR_XLEN-1:0] epc_i,
  input  logic                 mret_i,
  // to the fetch unit
  output logic [`CSR_XLEN-1:0] tvec_o,
  output logic [`CSR_XLEN-1:0] epc_o,
  output logic                 mie_o
);

  import csr_isa_pkg::*;

  // storage, mstatus is only two bits
  logic                 st_mie;
  logic                 st_mpie;
  logic [`CSR_XLEN-1:0] mtvec;
  logic [`CSR_XLEN-1:0] mscratch;
  logic [`CSR_XLEN-1:0] mepc;
  logic [`CSR_XLEN-1:0] mcause;

  logic [`CSR_XLEN-1:0] mstatus_rd;  // assembled view
  logic [`CSR_XLEN-1:0] wr_val;      // result of the op
  logic                 wr_en;

  //////////////////////////////////////////////////////////////////////
  // read decode
  //////////////////////////////////////////////////////////////////////

  always_comb begin
    mstatus_rd        = '0;
    mstatus_rd[12:11] = 2'b11;    // MPP, always machine
    mstatus_rd[7]     = st_mpie;
    mstatus_rd[3]     = st_mie;
  end

  always_comb begin
    case (bus_adr_i)
      MSTATUS:  bus_rdata_o = mstatus_rd;
      MISA:     bus_rdata_o = `CSR_MISA_VAL;
      MTVEC:    bus_rdata_o = mtvec;
      MSCRATCH: bus_rdata_o = mscratch;
      MEPC:     bus_rdata_o = mepc;
      MCAUSE:   bus_rdata_o = mcause;
      default:  bus_rdata_o = '0;  // unimplemented
    endcase
  end

  // read-modify-write on the old value
  always_comb begin
    case (bus_op_i)
      CSR_RW:  wr_val = bus_opd_i;
      CSR_SET: wr_val = bus_rdata_o | bus_opd_i;
      CSR_CLR: wr_val = bus_rdata_o & ~bus_opd_i;
      default: wr_val = bus_rdata_o;
    endcase
  end

  assign wr_en       = bus_we_i && (bus_op_i != CSR_NOP);
  assign bus_ready_o = !(trap_i || mret_i);  // bus stalls for trap/mret

  //////////////////////////////////////////////////////////////////////
  // register update
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      st_mie   <= 1'b0;
      st_mpie  <= 1'b0;
      mtvec    <= `CSR_MTVEC_RST;
      mscratch <= '0;
      mepc     <= '0;
      mcause   <= '0;
    end else if (trap_i) begin
      mepc    <= {epc_i[`CSR_XLEN-1:2], 2'b00};
      mcause  <= cause_i;
      st_mpie <= st_mie;  // stack the enable
      st_mie  <= 1'b0;
    end else if (mret_i) begin
      st_mie  <= st_mpie;
      st_mpie <= 1'b1;
    end else if (wr_en) begin
      case (bus_adr_i)
        MSTATUS: begin
          st_mie  <= wr_val[3];
          st_mpie <= wr_val[7];
        end
        MTVEC:    mtvec    <= {wr_val[`CSR_XLEN-1:2], 2'b00};  // direct only
        MSCRATCH: mscratch <= wr_val;
        MEPC:     mepc     <= {wr_val[`CSR_XLEN-1:2], 2'b00};
        MCAUSE:   mcause   <= wr_val;
        default: ;  // misa and unknown addresses
      endcase
    end
  end

  assign tvec_o = mtvec;
  assign epc_o  = mepc;
  assign mie_o  = st_mie;

  // trap and mret come from different pipeline events
  a_trap_mret: assert property (@(posedge clk) disable iff (rst)
    !(trap_i && mret_i))
    else $error("regfile: trap and mret together");

endmodule

// ==== source/csr_top.sv ====
//////////////////////////////////////////////////////////////////////
// machine CSR block with its core and host masters
// both masters share the register file through the arbiter
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_top (
  input  logic                  clk,
  input  logic                  rst,
  // Zicsr commands
  input  logic                  csr_valid_i,
  input  csr_isa_pkg::csr_op_t  csr_op_i,
  input  csr_isa_pkg::csr_src_t csr_src_i,
  input  logic [`CSR_AW-1:0]    csr_adr_i,
  input  logic [4:0]            csr_imm_i,
  input  logic [`CSR_XLEN-1:0]  csr_rs1_i,
  output logic                  csr_done_o,
  output logic [`CSR_XLEN-1:0]  csr_rd_o,
  // host port
  input  logic                  host_rd_i,
  input  logic                  host_wr_i,
  input  logic [`CSR_AW-1:0]    host_adr_i,
  input  logic [`CSR_XLEN-1:0]  host_wdata_i,
  output logic                  host_ack_o,
  output logic [`CSR_XLEN-1:0]  host_rdata_o,
  // traps
  input  logic                  trap_i,
  input  logic [`CSR_XLEN-1:0]  cause_i,
  input  logic [`CSR_XLEN-1:0]  epc_i,
  input  logic                  mret_i,
  output logic [`CSR_XLEN-1:0]  tvec_o,
  output logic [`CSR_XLEN-1:0]  epc_o,
  output logic                  mie_o
);

  import csr_isa_pkg::*;

  // core master to arbiter
  logic                 core_req, core_gnt;
  csr_op_t              core_op;
  logic [`CSR_AW-1:0]   core_adr;
  logic [`CSR_XLEN-1:0] core_opd, core_rdata;
  // host master to arbiter
  logic                 host_req, host_gnt;
  csr_op_t              host_op;
  logic [`CSR_AW-1:0]   host_adr;
  logic [`CSR_XLEN-1:0] host_opd, host_rdata;
  // shared bus
  logic                 bus_we, bus_ready;
  csr_op_t              bus_op;
  logic [`CSR_AW-1:0]   bus_adr;
  logic [`CSR_XLEN-1:0] bus_opd, bus_rdata;

  csr_zicsr_unit u_zicsr (
    .clk, .rst,
    .csr_valid_i, .csr_op_i, .csr_src_i, .csr_adr_i, .csr_imm_i, .csr_rs1_i,
    .req_o (core_req), .op_o (core_op), .adr_o (core_adr), .opd_o (core_opd),
    .gnt_i (core_gnt), .rdata_i (core_rdata),
    .csr_done_o, .csr_rd_o
  );

  csr_host_port u_host (
    .clk, .rst,
    .host_rd_i, .host_wr_i, .host_adr_i, .host_wdata_i,
    .req_o (host_req), .op_o (host_op), .adr_o (host_adr), .opd_o (host_opd),
    .gnt_i (host_gnt), .rdata_i (host_rdata),
    .host_ack_o, .host_rdata_o
  );

  csr_arbiter u_arb (
    .clk, .rst,
    .core_req_i (core_req), .core_op_i (core_op), .core_adr_i (core_adr),
    .core_opd_i (core_opd), .core_gnt_o (core_gnt), .core_rdata_o (core_rdata),
    .host_req_i (host_req), .host_op_i (host_op), .host_adr_i (host_adr),
    .host_opd_i (host_opd), .host_gnt_o (host_gnt), .host_rdata_o (host_rdata),
    .bus_ready_i (bus_ready), .bus_we_o (bus_we), .bus_op_o (bus_op),
    .bus_adr_o (bus_adr), .bus_opd_o (bus_opd), .bus_rdata_i (bus_rdata)
  );

  csr_regfile u_regs (
    .clk, .rst,
    .bus_we_i (bus_we), .bus_op_i (bus_op), .bus_adr_i (bus_adr),
    .bus_opd_i (bus_opd), .bus_rdata_o (bus_rdata), .bus_ready_o (bus_ready),
    .trap_i, .cause_i, .epc_i, .mret_i,
    .tvec_o, .epc_o, .mie_o
  );

endmodule

// ==== source/csr_zicsr_unit.sv ====
//////////////////////////////////////////////////////////////////////
// core side CSR bus master, runs one Zicsr command at a time
// pulse csr_valid_i, wait for csr_done_o, old value on csr_rd_o
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_zicsr_unit (
  input  logic                  clk,
  input  logic                  rst,
  // command from the execute stage
  input  logic                  csr_valid_i,  // one cycle pulse
  input  csr_isa_pkg::csr_op_t  csr_op_i,
  input  csr_isa_pkg::csr_src_t csr_src_i,
  input  logic [`CSR_AW-1:0]    csr_adr_i,
  input  logic [4:0]            csr_imm_i,    // zimm field
  input  logic [`CSR_XLEN-1:0]  csr_rs1_i,
  // CSR bus request side
  output logic                  req_o,
  output csr_isa_pkg::csr_op_t  op_o,
  output logic [`CSR_AW-1:0]    adr_o,
  output logic [`CSR_XLEN-1:0]  opd_o,
  input  logic                  gnt_i,
  input  logic [`CSR_XLEN-1:0]  rdata_i,      // old register value
  // completion
  output logic                  csr_done_o,
  output logic [`CSR_XLEN-1:0]  csr_rd_o
);

  import csr_isa_pkg::*;

  logic [`CSR_XLEN-1:0] opd_sel;  // operand before latching
  logic                 accept;   // new command taken this edge

  // operand select, immediate is zero extended
  always_comb begin
    case (csr_src_i)
      CSR_IMM: opd_sel = {{(`CSR_XLEN-5){1'b0}}, csr_imm_i};
      default: opd_sel = csr_rs1_i;
    endcase
  end

  assign accept = csr_valid_i && !req_o;  // pulses while busy are lost

  // request and done, control state
  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      req_o      <= 1'b0;
      csr_done_o <= 1'b0;
    end else begin
      csr_done_o <= req_o && gnt_i;  // one cycle after the grant
      if (accept) begin
        req_o <= 1'b1;
      end else if (gnt_i) begin
        req_o <= 1'b0;
      end
    end
  end

  // command payload, held until granted
  always_ff @(posedge clk) begin
    if (accept) begin
      op_o  <= csr_op_i;
      adr_o <= csr_adr_i;
      opd_o <= opd_sel;
    end
    if (req_o && gnt_i) begin
      csr_rd_o <= rdata_i;  // old value for rd
    end
  end

  // the pipeline must not issue a second CSR op before done
  a_no_overrun: assert property (@(posedge clk) disable iff (rst)
    csr_valid_i |-> !req_o)
    else $error("zicsr: command dropped, unit still busy");

endmodule

// ==== test/csr_tb.sv ====
//////////////////////////////////////////////////////////////////////
// testbench for the machine CSR block with table rows and a random phase
// built and run by the Makefile run target
//////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_tb;

  import csr_isa_pkg::*;

  // row kinds of the stimulus table
  typedef enum int {K_CORE, K_HRD, K_HWR, K_TRAP, K_MRET, K_CONT, K_STALL, K_TVEC} kind_t;

  localparam int N_RAND = 24;                       // random ops on mscratch
  localparam logic [`CSR_XLEN-1:0] STALL_EPC   = 32'h0000_0104;
  localparam logic [`CSR_XLEN-1:0] STALL_CAUSE = 32'h0000_0007;

  logic                 clk, rst;
  logic                 csr_valid, host_rd, host_wr, trap, mret;
  csr_op_t              csr_op;
  csr_src_t             csr_src;
  logic [`CSR_AW-1:0]   csr_adr, host_adr;
  logic [4:0]           csr_imm;
  logic [`CSR_XLEN-1:0] csr_rs1, host_wdata, cause, epc;
  logic                 csr_done, host_ack, mie;
  logic [`CSR_XLEN-1:0] csr_rd, host_rdata, tvec, epc_out;

  // stimulus table as one queue per column
  kind_t                kind_q[$];
  csr_op_t              op_q[$];
  csr_src_t             src_q[$];
  logic [`CSR_AW-1:0]   adr_q[$];
  logic [4:0]           imm_q[$];
  logic [`CSR_XLEN-1:0] data_q[$];
  logic [`CSR_XLEN-1:0] exp_q[$];   // old value, read value or output

  int          n_checks, n_mismatch, n_other;
  int          cycles, cycle_limit;
  logic [31:0] seed;
  bit          tie_core_first;      // expected round-robin winner

  csr_top u_dut (
    .clk (clk), .rst (rst),
    .csr_valid_i (csr_valid), .csr_op_i (csr_op), .csr_src_i (csr_src),
    .csr_adr_i (csr_adr), .csr_imm_i (csr_imm), .csr_rs1_i (csr_rs1),
    .csr_done_o (csr_done), .csr_rd_o (csr_rd),
    .host_rd_i (host_rd), .host_wr_i (host_wr), .host_adr_i (host_adr),
    .host_wdata_i (host_wdata), .host_ack_o (host_ack), .host_rdata_o (host_rdata),
    .trap_i (trap), .cause_i (cause), .epc_i (epc), .mret_i (mret),
    .tvec_o (tvec), .epc_o (epc_out), .mie_o (mie)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;  // 4 ns period
  end

  // run limit in clock cycles
  initial begin
    cycles = 0;
    while (cycles <= cycle_limit) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: DUT gave no response within %0d cycles", cycle_limit);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model and checks
  //////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] lcg_step(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  function automatic logic [31:0] pick_operand(input csr_src_t src, input logic [4:0] imm,
                                               input logic [31:0] rs1);
    return (src == CSR_IMM) ? {27'b0, imm} : rs1;  // zimm zero extended
  endfunction

  // new register value per Zicsr rules
  function automatic logic [31:0] csr_result(input csr_op_t op, input logic [31:0] old,
                                             input logic [31:0] opd);
    case (op)
      CSR_RW:  return opd;
      CSR_SET: return old | opd;
      CSR_CLR: return old & ~opd;
      default: return old;
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    n_checks++;
    assert (got === exp) else begin
      n_mismatch++;
      $display("mismatch %s: got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_cond(input bit ok, input string what);
    n_checks++;
    assert (ok) else begin
      n_other++;
      $display("error: %s", what);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // drive helpers that change inputs 1 ns after the rising edge
  //////////////////////////////////////////////////////////////////////

  task automatic tick();
    @(posedge clk);
    #1;
  endtask

  task automatic clear_pulses();
    csr_valid = 1'b0;
    host_rd   = 1'b0;
    host_wr   = 1'b0;
    trap      = 1'b0;
    mret      = 1'b0;
  endtask

  task automatic drive_core(input csr_op_t op, input csr_src_t src, input logic [11:0] adr,
                            input logic [4:0] imm, input logic [31:0] rs1);
    csr_valid = 1'b1;
    csr_op    = op;
    csr_src   = src;
    csr_adr   = adr;
    csr_imm   = imm;
    csr_rs1   = rs1;
  endtask

  task automatic drive_host(input bit wr, input logic [11:0] adr, input logic [31:0] data);
    host_rd    = !wr;
    host_wr    = wr;
    host_adr   = adr;
    host_wdata = data;
  endtask

  // lat counts cycles from the command pulse to done/ack
  task automatic wait_done(output int lat);
    lat = 1;
    tick();
    clear_pulses();
    while (!csr_done) begin
      tick();
      lat++;
    end
  endtask

  task automatic wait_ack(output int lat);
    lat = 1;
    tick();
    clear_pulses();
    while (!host_ack) begin
      tick();
      lat++;
    end
  endtask

  task automatic add_row(input kind_t kind, input csr_op_t op, input csr_src_t src,
                         input logic [11:0] adr, input logic [4:0] imm,
                         input logic [31:0] data, input logic [31:0] exp);
    kind_q.push_back(kind);
    op_q.push_back(op);
    src_q.push_back(src);
    adr_q.push_back(adr);
    imm_q.push_back(imm);
    data_q.push_back(data);
    exp_q.push_back(exp);
  endtask

  task automatic load_table();
    // Zicsr ops on mscratch with both sources
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSCRATCH, 5'h00, 32'h0000_0000, 32'h0000_0000);
    add_row(K_CORE, CSR_RW,  CSR_REG, MSCRATCH, 5'h00, 32'h1234_5678, 32'h0000_0000);
    add_row(K_CORE, CSR_SET, CSR_IMM, MSCRATCH, 5'h11, 32'h0000_0000, 32'h1234_5678);
    add_row(K_CORE, CSR_CLR, CSR_REG, MSCRATCH, 5'h00, 32'hffff_0000, 32'h1234_5679);
    add_row(K_CORE, CSR_CLR, CSR_IMM, MSCRATCH, 5'h19, 32'h0000_0000, 32'h0000_5679);
    add_row(K_CORE, CSR_RW,  CSR_IMM, MSCRATCH, 5'h1f, 32'h0000_0000, 32'h0000_5660);
    add_row(K_CORE, CSR_SET, CSR_REG, MSCRATCH, 5'h00, 32'ha500_0000, 32'h0000_001f);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSCRATCH, 5'h00, 32'h0000_0000, 32'ha500_001f);
    add_row(K_CORE, CSR_NOP, CSR_REG, MSCRATCH, 5'h00, 32'hffff_ffff, 32'ha500_001f);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSCRATCH, 5'h00, 32'h0000_0000, 32'ha500_001f);
    // field masking
    add_row(K_HWR,  CSR_NOP, CSR_REG, MISA,     5'h00, 32'h0000_0000, `CSR_MISA_VAL);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MISA,     5'h00, 32'h0000_0000, `CSR_MISA_VAL);
    add_row(K_CORE, CSR_RW,  CSR_REG, MSTATUS,  5'h00, 32'hffff_ffff, 32'h0000_1800);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1888);
    add_row(K_CORE, CSR_CLR, CSR_IMM, MSTATUS,  5'h08, 32'h0000_0000, 32'h0000_1888);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1880);
    add_row(K_CORE, CSR_SET, CSR_IMM, MSTATUS,  5'h08, 32'h0000_0000, 32'h0000_1880);
    add_row(K_HWR,  CSR_NOP, CSR_REG, MTVEC,    5'h00, 32'h8000_0203, `CSR_MTVEC_RST);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MTVEC,    5'h00, 32'h0000_0000, 32'h8000_0200);
    add_row(K_TVEC, CSR_NOP, CSR_REG, MTVEC,    5'h00, 32'h0000_0000, 32'h8000_0200);
    add_row(K_HWR,  CSR_NOP, CSR_REG, MEPC,     5'h00, 32'h0000_1237, 32'h0000_0000);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MEPC,     5'h00, 32'h0000_0000, 32'h0000_1234);
    add_row(K_HWR,  CSR_NOP, CSR_REG, 12'h7c0,  5'h00, 32'hdead_beef, 32'h0000_0000);
    add_row(K_HRD,  CSR_NOP, CSR_REG, 12'h7c0,  5'h00, 32'h0000_0000, 32'h0000_0000);
    // trap rows carry epc in data, cause in imm and epc_o in exp
    add_row(K_TRAP, CSR_NOP, CSR_REG, MEPC,     5'd11, 32'h0000_4446, 32'h0000_4444);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MCAUSE,   5'h00, 32'h0000_0000, 32'h0000_000b);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MEPC,     5'h00, 32'h0000_0000, 32'h0000_4444);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1880);
    add_row(K_MRET, CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_0001);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1888);
    add_row(K_CORE, CSR_CLR, CSR_IMM, MSTATUS,  5'h08, 32'h0000_0000, 32'h0000_1888);
    add_row(K_TRAP, CSR_NOP, CSR_REG, MEPC,     5'd2,  32'h0000_8000, 32'h0000_8000);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1800);
    add_row(K_MRET, CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_0000);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSTATUS,  5'h00, 32'h0000_0000, 32'h0000_1880);
    // ties of a core op against a host read of the same CSR
    add_row(K_CONT, CSR_SET, CSR_REG, MSCRATCH, 5'h00, 32'h0000_0f00, 32'ha500_001f);
    add_row(K_CONT, CSR_CLR, CSR_REG, MSCRATCH, 5'h00, 32'ha500_0000, 32'ha500_0f1f);
    add_row(K_CONT, CSR_RW,  CSR_IMM, MSCRATCH, 5'h05, 32'h0000_0000, 32'h0000_0f1f);
    // command stalled by a trap
    add_row(K_STALL, CSR_RW, CSR_REG, MSCRATCH, 5'h00, 32'h5555_aaaa, 32'h0000_0005);
    add_row(K_HRD,  CSR_NOP, CSR_REG, MSCRATCH, 5'h00, 32'h0000_0000, 32'h5555_aaaa);
  endtask

  //////////////////////////////////////////////////////////////////////
  // row and random phase execution
  //////////////////////////////////////////////////////////////////////

  task automatic apply_row(input int i);
    int          lat, n, core_at, host_at;
    logic [31:0] host_exp;
    case (kind_q[i])
      K_CORE: begin
        drive_core(op_q[i], src_q[i], adr_q[i], imm_q[i], data_q[i]);
        wait_done(lat);
        check_value("csr_rd_o", csr_rd, exp_q[i]);
      end
      K_HRD, K_HWR: begin
        drive_host(kind_q[i] == K_HWR, adr_q[i], data_q[i]);
        wait_ack(lat);
        check_value("host_rdata_o", host_rdata, exp_q[i]);
      end
      K_TRAP: begin
        trap  = 1'b1;
        epc   = data_q[i];
        cause = {27'b0, imm_q[i]};
        tick();
        clear_pulses();
        check_value("epc_o", epc_out, exp_q[i]);
        check_value("mie_o", {31'b0, mie}, 32'h0);
      end
      K_MRET: begin
        mret = 1'b1;
        tick();
        clear_pulses();
        check_value("mie_o", {31'b0, mie}, exp_q[i]);
      end
      K_TVEC: check_value("tvec_o", tvec, exp_q[i]);
      K_CONT: begin
        drive_core(op_q[i], src_q[i], adr_q[i], imm_q[i], data_q[i]);
        drive_host(1'b0, adr_q[i], 32'h0);
        tick();
        clear_pulses();
        n       = 1;
        core_at = 0;
        host_at = 0;
        while (core_at == 0 || host_at == 0) begin
          tick();
          n++;
          if (csr_done) core_at = n;
          if (host_ack) host_at = n;
        end
        // host sees the new value only if the core went first
        host_exp = tie_core_first ?
          csr_result(op_q[i], exp_q[i], pick_operand(src_q[i], imm_q[i], data_q[i])) :
          exp_q[i];
        check_value("csr_rd_o", csr_rd, exp_q[i]);
        check_value("host_rdata_o", host_rdata, host_exp);
        check_cond((core_at < host_at) == tie_core_first,
                   $sformatf("tie in row %0d served in the wrong order", i));
        tie_core_first = !tie_core_first;
      end
      K_STALL: begin
        drive_core(op_q[i], src_q[i], adr_q[i], imm_q[i], data_q[i]);
        tick();
        clear_pulses();
        trap  = 1'b1;  // lands on the request cycle
        epc   = STALL_EPC;
        cause = STALL_CAUSE;
        tick();
        clear_pulses();
        lat = 2;
        while (!csr_done) begin
          tick();
          lat++;
        end
        check_value("csr_rd_o", csr_rd, exp_q[i]);
        check_value("epc_o", epc_out, STALL_EPC);
        check_cond(lat == 3, $sformatf("stalled command took %0d cycles, expected 3", lat));
      end
      default: check_cond(1'b0, $sformatf("row %0d has an unknown kind", i));
    endcase
  endtask

  task automatic run_random(input int count);
    logic [31:0] model, r, data;
    csr_op_t     op;
    csr_src_t    src;
    logic [4:0]  imm;
    int          lat;
    model = exp_q[exp_q.size()-1];  // last table row reads mscratch
    for (int i = 0; i < count; i++) begin
      seed = lcg_step(seed);
      r    = seed;
      seed = lcg_step(seed);
      data = seed;
      op   = csr_op_t'(r[31:30]);   // upper LCG bits spread better
      src  = csr_src_t'(r[29]);
      imm  = r[28:24];
      if (op == CSR_NOP) begin
        drive_host(1'b1, MSCRATCH, data);  // plain host write
        wait_ack(lat);
        check_value("host_rdata_o", host_rdata, model);
        model = data;
      end else begin
        drive_core(op, src, MSCRATCH, imm, data);
        wait_done(lat);
        check_value("csr_rd_o", csr_rd, model);
        model = csr_result(op, model, pick_operand(src, imm, data));
      end
    end
    drive_host(1'b0, MSCRATCH, 32'h0);
    wait_ack(lat);
    check_value("host_rdata_o", host_rdata, model);
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst        = 1'b1;
    csr_op     = CSR_NOP;
    csr_src    = CSR_REG;
    csr_adr    = '0;
    csr_imm    = '0;
    csr_rs1    = '0;
    host_adr   = '0;
    host_wdata = '0;
    cause      = '0;
    epc        = '0;
    clear_pulses();
    n_checks       = 0;
    n_mismatch     = 0;
    n_other        = 0;
    seed           = 32'ha7eb;
    tie_core_first = 1'b1;  // arbiter favours the core after reset
    load_table();
    cycle_limit = (kind_q.size() + N_RAND + 1) * 20 + 200;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;
    tick();
    for (int i = 0; i < kind_q.size(); i++) begin
      apply_row(i);
    end
    run_random(N_RAND);
    $display("checks %0d, mismatches %0d, other errors %0d", n_checks, n_mismatch, n_other);
    if (n_mismatch == 0 && n_other == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog.f ====
+incdir+source
source/csr_isa_pkg.sv
source/csr_bus_pkg.sv
source/csr_zicsr_unit.sv
source/csr_host_port.sv
source/csr_arbiter.sv
source/csr_regfile.sv
source/csr_top.sv
test/csr_tb.sv
